// File: src/cache_pkg.sv
// Cache shared types
`default_nettype none

package cache_pkg;

    // byte address seen by requester and physical memory
    typedef logic [31:0] addr_t;

    localparam int line_bits = 256;

    typedef enum logic [1:0]
    {
        st_compare,     // idle or tag check
        st_writeback,   // dirty victim out
        st_allocate,    // line fetch
        st_refill_wait  // arrays settle before recheck
    } cache_state_e;

endpackage : cache_pkg

`default_nettype wire

// File: src/cache_ctrl_if.sv
// Controller to datapath strobes
`timescale 1ns/100ps
`default_nettype none

interface cache_ctrl_if;

    logic set_dirty;
    logic reset_dirty;
    logic set_valid;
    logic load_tag;
    logic set_lru;
    logic load_data;
    logic use_victim_addr; // pmem address from victim tag
    logic hit;
    logic dirty;           // victim way dirty

    modport control
    (
        output set_dirty, reset_dirty, set_valid, load_tag, set_lru, load_data,
        output use_victim_addr,
        input  hit, dirty
    );

    modport datapath
    (
        input  set_dirty, reset_dirty, set_valid, load_tag, set_lru, load_data,
        input  use_victim_addr,
        output hit, dirty
    );

endinterface : cache_ctrl_if

`default_nettype wire

// File: src/cache_meta_array.sv
// Per-set metadata registers
`timescale 1ns/100ps
`default_nettype none

module cache_meta_array #(
    parameter int width   = 1,
    parameter int s_index = 3
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,
    input  logic [s_index-1:0] index,
    input  logic [width-1:0]   datain,
    output logic [width-1:0]   dataout
);

    localparam int num_sets = 2**s_index;

    logic [width-1:0] data [num_sets];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < num_sets; i++)
                data[i] <= '0;
        end
        else if (load)
        begin
            data[index] <= datain;
        end
    end

    assign dataout = data[index]; // same-cycle read

endmodule : cache_meta_array

`default_nettype wire

// File: src/cache_line_array.sv
// Per-set line storage
`timescale 1ns/100ps
`default_nettype none

module cache_line_array #(
    parameter int s_index = 3
)
(
    input  logic                               clk,
    input  logic [cache_pkg::line_bits/8-1:0]  write_en,
    input  logic [s_index-1:0]                 index,
    input  logic [cache_pkg::line_bits-1:0]    datain,
    output logic [cache_pkg::line_bits-1:0]    dataout
);

    localparam int num_sets  = 2**s_index;
    localparam int num_bytes = cache_pkg::line_bits / 8;

    logic [cache_pkg::line_bits-1:0] data [num_sets];

    // bytewise write, no reset on payload
    always_ff @(posedge clk)
    begin
        for (int b = 0; b < num_bytes; b++)
        begin
            if (write_en[b])
                data[index][8*b +: 8] <= datain[8*b +: 8];
        end
    end

    assign dataout = data[index];

endmodule : cache_line_array

`default_nettype wire

// File: src/cache_datapath.sv
// Two-way cache datapath
`timescale 1ns/100ps
`default_nettype none

module cache_datapath #(
    parameter int s_offset = 5,
    parameter int s_index  = 3
)
(
    input  logic                               clk,
    input  logic                               rst_n,
    input  cache_pkg::addr_t                   mem_address,
    input  logic [cache_pkg::line_bits/8-1:0]  mem_byte_enable256,
    input  logic [cache_pkg::line_bits-1:0]    mem_wdata256,
    input  logic [cache_pkg::line_bits-1:0]    pmem_rdata,
    output logic [cache_pkg::line_bits-1:0]    mem_rdata256,
    output logic [cache_pkg::line_bits-1:0]    pmem_wdata,
    output cache_pkg::addr_t                   pmem_address,
    cache_ctrl_if.datapath                     dp
);

    localparam int s_tag     = 32 - s_offset - s_index;
    localparam int num_bytes = cache_pkg::line_bits / 8;

    logic [s_tag-1:0]                 req_tag;
    logic [s_index-1:0]               req_idx;
    logic [s_tag-1:0]                 way_tag   [2];
    logic [cache_pkg::line_bits-1:0]  way_line  [2];
    logic [num_bytes-1:0]             way_we    [2];
    logic [1:0]                       way_valid;
    logic [1:0]                       way_dirty;
    logic [1:0]                       way_hit;
    logic [1:0]                       tag_load;
    logic [1:0]                       valid_load;
    logic [1:0]                       dirty_load;
    logic [1:0]                       victim_sel;
    logic                             lru_out;
    logic                             lru_in;
    logic [cache_pkg::line_bits-1:0]  line_din;

    assign req_tag = mem_address[31 -: s_tag];
    assign req_idx = mem_address[s_offset +: s_index];

    // lru bit names the victim way
    assign victim_sel = lru_out ? 2'b10 : 2'b01;

    assign dp.hit   = |way_hit;
    assign dp.dirty = way_dirty[lru_out];
    assign lru_in   = way_hit[0]; // point at the way not hit

    assign tag_load   = dp.load_tag  ? victim_sel : 2'b00;
    assign valid_load = dp.set_valid ? victim_sel : 2'b00;
    assign dirty_load = (dp.set_dirty ? way_hit : 2'b00)
                      | (dp.reset_dirty ? victim_sel : 2'b00);

    assign line_din = dp.load_tag ? pmem_rdata : mem_wdata256; // fill or write hit

    always_comb
    begin
        for (int w = 0; w < 2; w++)
        begin
            way_we[w] = '0;
            if (dp.load_data)
            begin
                if (dp.load_tag)
                    way_we[w] = victim_sel[w] ? '1 : '0;
                else if (way_hit[w])
                    way_we[w] = mem_byte_enable256;
            end
        end
    end

    assign mem_rdata256 = way_hit[1] ? way_line[1] : way_line[0];
    assign pmem_wdata   = way_line[lru_out];
    assign pmem_address = dp.use_victim_addr
                        ? {way_tag[lru_out], req_idx, {s_offset{1'b0}}}
                        : {req_tag, req_idx, {s_offset{1'b0}}};

    for (genvar w = 0; w < 2; w++)
    begin : g_way
        assign way_hit[w] = way_valid[w] && (way_tag[w] == req_tag);

        cache_line_array #(.s_index(s_index)) u_line
        (
            .clk      (clk),
            .write_en (way_we[w]),
            .index    (req_idx),
            .datain   (line_din),
            .dataout  (way_line[w])
        );

        cache_meta_array #(.width(s_tag), .s_index(s_index)) u_tag
        (
            .clk(clk), .rst_n(rst_n), .load(tag_load[w]), .index(req_idx),
            .datain(req_tag), .dataout(way_tag[w])
        );

        cache_meta_array #(.width(1), .s_index(s_index)) u_valid
        (
            .clk(clk), .rst_n(rst_n), .load(valid_load[w]), .index(req_idx),
            .datain(1'b1), .dataout(way_valid[w])
        );

        cache_meta_array #(.width(1), .s_index(s_index)) u_dirty
        (
            .clk(clk), .rst_n(rst_n), .load(dirty_load[w]), .index(req_idx),
            .datain(dp.set_dirty), .dataout(way_dirty[w])
        );
    end

    cache_meta_array #(.width(1), .s_index(s_index)) u_lru
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (dp.set_lru),
        .index   (req_idx),
        .datain  (lru_in),
        .dataout (lru_out)
    );

    // a tag lives in at most one way of a set
    a_single_way_hit : assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(way_hit)
    ) else $error("both ways hit for index %0d", req_idx);

endmodule : cache_datapath

`default_nettype wire

// File: src/cache_control.sv
// Cache miss and writeback FSM
`timescale 1ns/100ps
`default_nettype none

module cache_control
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          mem_read,
    input  logic          mem_write,
    input  logic          pmem_resp,
    output logic          mem_resp,
    output logic          pmem_read,
    output logic          pmem_write,
    cache_ctrl_if.control ctrl
);

    cache_pkg::cache_state_e state;
    cache_pkg::cache_state_e state_next;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= cache_pkg::st_compare;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next           = state;
        mem_resp             = 1'b0;
        pmem_read            = 1'b0;
        pmem_write           = 1'b0;
        ctrl.set_dirty       = 1'b0;
        ctrl.reset_dirty     = 1'b0;
        ctrl.set_valid       = 1'b0;
        ctrl.load_tag        = 1'b0;
        ctrl.set_lru         = 1'b0;
        ctrl.load_data       = 1'b0;
        ctrl.use_victim_addr = 1'b0;

        unique case (state)
            cache_pkg::st_compare:
            begin
                if (mem_read || mem_write)
                begin
                    if (ctrl.hit)
                    begin
                        mem_resp     = 1'b1;
                        ctrl.set_lru = 1'b1;
                        if (mem_write)
                        begin
                            ctrl.set_dirty = 1'b1;
                            ctrl.load_data = 1'b1; // byte merge into hit way
                        end
                    end
                    else if (ctrl.dirty)
                        state_next = cache_pkg::st_writeback;
                    else
                        state_next = cache_pkg::st_allocate;
                end
            end
            cache_pkg::st_writeback:
            begin
                ctrl.use_victim_addr = 1'b1;
                pmem_write           = 1'b1;
                if (pmem_resp)
                begin
                    ctrl.reset_dirty = 1'b1;
                    state_next       = cache_pkg::st_allocate;
                end
            end
            cache_pkg::st_allocate:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    ctrl.load_data = 1'b1;
                    ctrl.load_tag  = 1'b1;
                    ctrl.set_valid = 1'b1;
                    state_next     = cache_pkg::st_refill_wait;
                end
            end
            cache_pkg::st_refill_wait:
            begin
                state_next = cache_pkg::st_compare; // recheck now hits
            end
            default:
            begin
                state_next = cache_pkg::st_compare;
            end
        endcase
    end

    // victim stays dirty for the whole writeback
    a_writeback_dirty : assert property (
        @(posedge clk) disable iff (!rst_n) pmem_write |-> ctrl.dirty
    ) else $error("writeback of a clean victim");

    // filled way answers the held request
    a_refill_hits : assert property (
        @(posedge clk) disable iff (!rst_n)
            state == cache_pkg::st_refill_wait |-> ctrl.hit
    ) else $error("no hit after line fill");

endmodule : cache_control

`default_nettype wire

// File: src/cache.sv
// Two-way write-back cache
`timescale 1ns/100ps
`default_nettype none

module cache #(
    parameter int s_offset = 5,
    parameter int s_index  = 3
)
(
    input  logic                               clk,
    input  logic                               rst_n,
    input  cache_pkg::addr_t                   mem_address,
    input  logic                               mem_read,
    input  logic                               mem_write,
    input  logic [31:0]                        mem_byte_enable256,
    input  logic [cache_pkg::line_bits-1:0]    mem_wdata256,
    output logic [cache_pkg::line_bits-1:0]    mem_rdata256,
    output logic                               mem_resp,
    output cache_pkg::addr_t                   pmem_address,
    output logic                               pmem_read,
    output logic                               pmem_write,
    output logic [cache_pkg::line_bits-1:0]    pmem_wdata,
    input  logic [cache_pkg::line_bits-1:0]    pmem_rdata,
    input  logic                               pmem_resp
);

    cache_ctrl_if ctrl_if ();

    cache_control u_control
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .pmem_resp  (pmem_resp),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .ctrl       (ctrl_if.control)
    );

    cache_datapath #(.s_offset(s_offset), .s_index(s_index)) u_datapath
    (
        .clk                (clk),
        .rst_n              (rst_n),
        .mem_address        (mem_address),
        .mem_byte_enable256 (mem_byte_enable256),
        .mem_wdata256       (mem_wdata256),
        .pmem_rdata         (pmem_rdata),
        .mem_rdata256       (mem_rdata256),
        .pmem_wdata         (pmem_wdata),
        .pmem_address       (pmem_address),
        .dp                 (ctrl_if.datapath)
    );

endmodule : cache

`default_nettype wire

// File: tests/cache_mem_model.sv
// Behavioral physical memory
`timescale 1ns/100ps
`default_nettype none

module cache_mem_model
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  cache_pkg::addr_t                 pmem_address,
    input  logic                             pmem_read,
    input  logic                             pmem_write,
    input  logic [cache_pkg::line_bits-1:0]  pmem_wdata,
    output logic [cache_pkg::line_bits-1:0]  pmem_rdata,
    output logic                             pmem_resp
);

    logic [cache_pkg::line_bits-1:0] mem [cache_pkg::addr_t];
    cache_pkg::addr_t                wr_addr_log [$];
    logic [cache_pkg::line_bits-1:0] wr_data_log [$];
    cache_pkg::addr_t                rd_addr_log [$];
    int   op_count   = 0;
    int   last_rd_op = 0;
    int   last_wr_op = 0;
    int   delay      = 0;
    logic busy       = 1'b0;

    // untouched lines, each word hashed from its byte address
    function automatic logic [cache_pkg::line_bits-1:0] fill_line(input cache_pkg::addr_t addr);
        logic [cache_pkg::line_bits-1:0] line;
        logic [31:0]                     h;
        for (int w = 0; w < 8; w++)
        begin
            h = (addr + 4 * w) * 32'h9e37_79b1;
            line[32*w +: 32] = h ^ (h >> 15) ^ 32'h6a09_e667;
        end
        return line;
    endfunction

    initial
    begin
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
    end

    always @(negedge clk)
    begin
        if (!rst_n || pmem_resp)
        begin
            pmem_resp <= 1'b0; // one cycle pulse
            busy = 1'b0;
        end
        else if (pmem_read || pmem_write)
        begin
            if (!busy)
            begin
                busy  = 1'b1;
                delay = $urandom_range(4, 1);
            end
            delay = delay - 1;
            if (delay == 0)
            begin
                op_count++;
                if (pmem_write)
                begin
                    mem[pmem_address] = pmem_wdata;
                    wr_addr_log.push_back(pmem_address);
                    wr_data_log.push_back(pmem_wdata);
                    last_wr_op = op_count;
                end
                else
                begin
                    rd_addr_log.push_back(pmem_address);
                    pmem_rdata <= mem.exists(pmem_address) ? mem[pmem_address]
                                                           : fill_line(pmem_address);
                    last_rd_op = op_count;
                end
                pmem_resp <= 1'b1;
            end
        end
    end

endmodule : cache_mem_model

`default_nettype wire

// File: tests/cache_tb.sv
// Cache testbench
`timescale 1ns/100ps
`default_nettype none

module cache_tb;

    localparam int resp_timeout = 200;

    logic                             clk = 1'b0;
    logic                             rst_n;
    cache_pkg::addr_t                 mem_address;
    logic                             mem_read;
    logic                             mem_write;
    logic [31:0]                      mem_byte_enable256;
    logic [cache_pkg::line_bits-1:0]  mem_wdata256;
    logic [cache_pkg::line_bits-1:0]  mem_rdata256;
    logic                             mem_resp;
    cache_pkg::addr_t                 pmem_address;
    logic                             pmem_read;
    logic                             pmem_write;
    logic [cache_pkg::line_bits-1:0]  pmem_wdata;
    logic [cache_pkg::line_bits-1:0]  pmem_rdata;
    logic                             pmem_resp;

    logic [cache_pkg::line_bits-1:0]  shadow [cache_pkg::addr_t]; // requester view
    int n_checks   = 0;
    int n_errors   = 0;
    int wb_checked = 0;
    int rd_mark;
    int wr_mark;

    cache #(.s_offset(5), .s_index(3)) dut0 (.*);
    cache_mem_model mem0 (.*);

    always #4 clk = ~clk;

    function automatic cache_pkg::addr_t line_addr(input cache_pkg::addr_t addr);
        return addr & ~32'h1f;
    endfunction

    // memory content before any writeback
    function automatic logic [255:0] pattern_line(input cache_pkg::addr_t addr);
        logic [255:0] line;
        logic [31:0]  h;
        for (int w = 0; w < 8; w++)
        begin
            h = (addr + 4 * w) * 32'h9e37_79b1;
            line[32*w +: 32] = h ^ (h >> 15) ^ 32'h6a09_e667;
        end
        return line;
    endfunction

    function automatic logic [255:0] ref_line(input cache_pkg::addr_t addr);
        if (shadow.exists(line_addr(addr)))
            return shadow[line_addr(addr)];
        return pattern_line(line_addr(addr));
    endfunction

    function automatic logic [255:0] rand_line();
        logic [255:0] line;
        for (int w = 0; w < 8; w++)
            line[32*w +: 32] = $urandom;
        return line;
    endfunction

    task automatic expect_equal(input logic [255:0] actual, input logic [255:0] expected,
                                input string what);
        n_checks++;
        if (actual !== expected)
        begin
            n_errors++;
            $display("** Error [%0t] %s: got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        $display("sim failed");
        $finish;
    endtask

    task automatic mark_traffic();
        rd_mark = mem0.rd_addr_log.size();
        wr_mark = mem0.wr_addr_log.size();
    endtask

    task automatic check_traffic(input int exp_reads, input int exp_writes, input string what);
        expect_equal(mem0.rd_addr_log.size() - rd_mark, exp_reads, {what, " fetches"});
        expect_equal(mem0.wr_addr_log.size() - wr_mark, exp_writes, {what, " writebacks"});
    endtask

    task automatic do_request(input logic is_write, input cache_pkg::addr_t addr,
                              input logic [31:0] be, input logic [255:0] wdata,
                              output int cycles);
        @(negedge clk);
        mem_address        = addr;
        mem_read           = !is_write;
        mem_write          = is_write;
        mem_byte_enable256 = be;
        mem_wdata256       = wdata;
        cycles             = 0;
        do
        begin
            @(posedge clk);
            cycles++;
        end
        while (!mem_resp && cycles < resp_timeout);
        if (!mem_resp)
            abort_run($sformatf("no mem_resp within %0d cycles for address %h", cycles, addr));
        else
        begin
            @(negedge clk);
            mem_read  = 1'b0;
            mem_write = 1'b0;
        end
    endtask

    // read data and writebacks against the shadow memory
    always @(posedge clk)
    begin : scoreboard
        logic [255:0] line;
        if (rst_n && mem_resp)
        begin
            line = ref_line(mem_address);
            if (mem_read)
                expect_equal(mem_rdata256, line, "read data");
            if (mem_write)
            begin
                for (int b = 0; b < 32; b++)
                    if (mem_byte_enable256[b])
                        line[8*b +: 8] = mem_wdata256[8*b +: 8];
                shadow[line_addr(mem_address)] = line;
            end
        end
        while (wb_checked < mem0.wr_addr_log.size())
        begin
            expect_equal(mem0.wr_data_log[wb_checked], ref_line(mem0.wr_addr_log[wb_checked]),
                         "writeback data");
            wb_checked++;
        end
    end

    initial
    begin : stimulus
        int               cycles;
        cache_pkg::addr_t a;

        void'($urandom(32'h051d_b96a));
        rst_n              = 1'b0;
        mem_address        = '0;
        mem_read           = 1'b0;
        mem_write          = 1'b0;
        mem_byte_enable256 = '0;
        mem_wdata256       = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        expect_equal(pmem_read, 1'b0, "pmem_read after reset");
        expect_equal(pmem_write, 1'b0, "pmem_write after reset");
        expect_equal(mem_resp, 1'b0, "mem_resp after reset");

        // first touch of set 1
        mark_traffic();
        do_request(1'b0, 32'h0000_102c, '0, '0, cycles);
        check_traffic(1, 0, "first read");
        expect_equal(mem0.rd_addr_log[$], 32'h0000_1020, "fetch address");

        mark_traffic();
        do_request(1'b0, 32'h0000_1024, '0, '0, cycles);
        expect_equal(cycles, 1, "read hit latency");
        check_traffic(0, 0, "read hit");

        do_request(1'b1, 32'h0000_1020, $urandom, rand_line(), cycles);
        expect_equal(cycles, 1, "write hit latency");
        do_request(1'b0, 32'h0000_1030, '0, '0, cycles);
        check_traffic(0, 0, "write hit");

        // C evicts B after A B A in set 2
        mark_traffic();
        do_request(1'b0, 32'h0000_2040, '0, '0, cycles);
        do_request(1'b0, 32'h0000_3040, '0, '0, cycles);
        do_request(1'b0, 32'h0000_2040, '0, '0, cycles);
        do_request(1'b0, 32'h0000_4040, '0, '0, cycles);
        check_traffic(3, 0, "clean eviction");
        mark_traffic();
        do_request(1'b0, 32'h0000_2044, '0, '0, cycles);
        expect_equal(cycles, 1, "lru keeps recent line");
        check_traffic(0, 0, "recent line");
        mark_traffic();
        do_request(1'b0, 32'h0000_3040, '0, '0, cycles);
        check_traffic(1, 0, "evicted line");

        // third read in set 3 writes back the older dirty line
        do_request(1'b1, 32'h0000_5060, $urandom, rand_line(), cycles);
        do_request(1'b1, 32'h0000_6060, $urandom, rand_line(), cycles);
        mark_traffic();
        do_request(1'b0, 32'h0000_7060, '0, '0, cycles);
        check_traffic(1, 1, "dirty eviction");
        expect_equal(mem0.wr_addr_log[$], 32'h0000_5060, "victim address");
        expect_equal(mem0.wr_data_log[$], ref_line(32'h0000_5060), "victim data");
        expect_equal(mem0.last_rd_op > mem0.last_wr_op, 1'b1, "fetch after writeback");

        // four tags per set over sets 4 to 7
        for (int i = 0; i < 300; i++)
        begin
            a = ((8 + $urandom_range(3, 0)) << 8) | ((4 + $urandom_range(3, 0)) << 5)
              | $urandom_range(31, 0);
            do_request($urandom_range(1, 0), a, $urandom, rand_line(), cycles);
        end

        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule : cache_tb

`default_nettype wire

// File: cache.f
src/cache_pkg.sv
src/cache_ctrl_if.sv
src/cache_meta_array.sv
src/cache_line_array.sv
src/cache_datapath.sv
src/cache_control.sv
src/cache.sv
tests/cache_mem_model.sv
tests/cache_tb.sv

// File: Bender.yml
package:
  name: cache

sources:
  - src/cache_pkg.sv
  - src/cache_ctrl_if.sv
  - src/cache_meta_array.sv
  - src/cache_line_array.sv
  - src/cache_datapath.sv
  - src/cache_control.sv
  - src/cache.sv
  - target: test
    files:
      - tests/cache_mem_model.sv
      - tests/cache_tb.sv
